/* bench/busModels.sv */
`timescale 1ns/1ps
// bench bus models
// PLB slave memory with ack delay and read error injection, plus a
// single-port block RAM with registered read data
module plbSlaveMem #(
  parameter int idxBits = 9
) (
  input  logic CLK,
  input  logic reset,
  // per-case response control
  input  logic [7:0] ackDelay,
  input  logic errEnable,
  input  logic [15:0] errRead,
  input  logic clearReads,
  // backdoor image load
  input  logic loadEn,
  input  logic [idxBits-1:0] loadIdx,
  input  logic [testerPkg::plbDataWidth-1:0] loadData,
  // PLB slave side
  input  logic mRequest,
  input  logic mRNW,
  input  logic [testerPkg::plbAddrWidth-1:0] mABus,
  input  logic [testerPkg::plbDataWidth-1:0] mWrDBus,
  output logic mAddrAck,
  output logic mWrDAck,
  output logic mRdDAck,
  output logic [testerPkg::plbDataWidth-1:0] mRdDBus,
  output logic mErr
);

  logic [testerPkg::plbDataWidth-1:0] mem [0:(1 << idxBits) - 1];
  logic busy;
  logic addrDone;
  logic isRead;
  logic failXfer;
  logic [7:0] waitCnt;
  logic [idxBits-1:0] idxQ;
  logic [testerPkg::plbDataWidth-1:0] dataQ;
  // reads since the last start
  logic [15:0] readCount;

  initial begin
    mAddrAck = 1'b0;
    mWrDAck = 1'b0;
    mRdDAck = 1'b0;
    mErr = 1'b0;
    mRdDBus = '0;
    busy = 1'b0;
  end

  always @(posedge CLK) begin
    if (loadEn) begin
      mem[loadIdx] <= loadData;
    end
    if (reset) begin
      busy <= 1'b0;
      addrDone <= 1'b0;
      readCount <= '0;
      mAddrAck <= 1'b0;
      mWrDAck <= 1'b0;
      mRdDAck <= 1'b0;
      mErr <= 1'b0;
    end else begin
      mAddrAck <= 1'b0;
      mWrDAck <= 1'b0;
      mRdDAck <= 1'b0;
      mErr <= 1'b0;
      if (clearReads) begin
        readCount <= '0;
      end
      if (!busy) begin
        // ack still on the bus means this request was just served
        if (mRequest && !mAddrAck) begin
          busy <= 1'b1;
          addrDone <= 1'b0;
          waitCnt <= ackDelay;
          isRead <= mRNW;
          idxQ <= mABus[3 +: idxBits];
          dataQ <= mWrDBus;
          failXfer <= mRNW && errEnable && (readCount == errRead);
          if (mRNW) begin
            readCount <= readCount + 16'd1;
          end
        end
      end else begin
        if (!addrDone) begin
          mAddrAck <= 1'b1;
          addrDone <= 1'b1;
        end
        if (waitCnt != 8'd0) begin
          waitCnt <= waitCnt - 8'd1;
        end else begin
          // data phase, err replaces the data ack
          busy <= 1'b0;
          if (failXfer) begin
            mErr <= 1'b1;
          end else if (isRead) begin
            mRdDAck <= 1'b1;
            mRdDBus <= mem[idxQ];
          end else begin
            mWrDAck <= 1'b1;
            mem[idxQ] <= dataQ;
          end
        end
      end
    end
  end

endmodule

// block RAM behind the FIFO, one 32-bit entry per word address
module blockRam (
  input  logic CLK,
  input  logic rst,
  input  logic en,
  input  logic [testerPkg::bramWenWidth-1:0] wen,
  input  logic [testerPkg::bramAddrWidth-1:0] addr,
  input  logic [testerPkg::bramDataWidth-1:0] wrData,
  output logic [testerPkg::bramDataWidth-1:0] rdData
);

  logic [testerPkg::bramDataWidth-1:0] mem [0:testerPkg::fifoDepth-1];
  logic [testerPkg::fifoAddrBits-1:0] idx;

  // byte address down to entry index
  assign idx = addr[2 +: testerPkg::fifoAddrBits];

  initial begin
    rdData = '0;
  end

  always @(posedge CLK) begin
    if (rst) begin
      rdData <= '0;
    end else if (en) begin
      if (wen == '1) begin
        mem[idx] <= wrData;
      end else begin
        rdData <= mem[idx];
      end
    end
  end

endmodule

/* bench/tbBramFifoTester.sv */
`timescale 1ns/1ps
// testbench for the BRAM FIFO tester
// runs a table of copy cases against a PLB memory model and a BRAM
// model and then compares each destination with the loaded image
module tbBramFifoTester;

  localparam int memWords = 512;
  localparam int numCases = 7;
  localparam int doneTimeout = 4000;

  // one copy case and what it should leave behind
  typedef struct packed {
    logic [31:0] srcBase;
    logic [31:0] dstBase;
    logic [15:0] wordCount;
    int ackDelay;
    // index of the read that gets mErr or -1 for none
    int errIdx;
    logic expError;
    // leading destination words that end up copied
    int expWritten;
  } caseRow;

  logic CLK = 1'b0;
  logic reset;
  logic start;
  logic [testerPkg::plbAddrWidth-1:0] srcBase;
  logic [testerPkg::plbAddrWidth-1:0] dstBase;
  logic [testerPkg::countWidth-1:0] wordCount;
  logic done;
  logic error;
  logic mRequest;
  logic mRNW;
  logic [testerPkg::plbAddrWidth-1:0] mABus;
  logic [testerPkg::plbBeWidth-1:0] mBE;
  logic [testerPkg::plbDataWidth-1:0] mWrDBus;
  logic mAddrAck;
  logic mWrDAck;
  logic mRdDAck;
  logic [testerPkg::plbDataWidth-1:0] mRdDBus;
  logic mErr;
  logic [testerPkg::bramAddrWidth-1:0] bramAddr;
  logic [testerPkg::bramDataWidth-1:0] bramDout;
  logic [testerPkg::bramWenWidth-1:0] bramWEN;
  logic bramEN;
  logic bramCLK;
  logic bramRST;
  logic [testerPkg::bramDataWidth-1:0] bramDin;

  // memory model control
  logic [7:0] ackDelay;
  logic errEnable;
  logic [15:0] errRead;
  logic loadEn;
  logic [8:0] loadIdx;
  logic [63:0] loadData;

  caseRow cases [numCases];
  logic [63:0] image [memWords];
  integer seed;
  int errorCount = 0;
  int reqCycles = 0;

  always #50 CLK = ~CLK;

  bramFifoTester i_bramFifoTester (
    .CLK(CLK), .reset(reset), .start(start), .srcBase(srcBase), .dstBase(dstBase),
    .wordCount(wordCount), .done(done), .error(error),
    .mRequest(mRequest), .mRNW(mRNW), .mABus(mABus), .mBE(mBE), .mWrDBus(mWrDBus),
    .mAddrAck(mAddrAck), .mWrDAck(mWrDAck), .mRdDAck(mRdDAck), .mRdDBus(mRdDBus),
    .mErr(mErr), .bramAddr(bramAddr), .bramDout(bramDout), .bramWEN(bramWEN),
    .bramEN(bramEN), .bramCLK(bramCLK), .bramRST(bramRST), .bramDin(bramDin)
  );

  plbSlaveMem i_plbSlaveMem (
    .CLK(CLK), .reset(reset), .ackDelay(ackDelay), .errEnable(errEnable),
    .errRead(errRead), .clearReads(start), .loadEn(loadEn), .loadIdx(loadIdx),
    .loadData(loadData), .mRequest(mRequest), .mRNW(mRNW), .mABus(mABus),
    .mWrDBus(mWrDBus), .mAddrAck(mAddrAck), .mWrDAck(mWrDAck), .mRdDAck(mRdDAck),
    .mRdDBus(mRdDBus), .mErr(mErr)
  );

  blockRam i_blockRam (
    .CLK(bramCLK), .rst(bramRST), .en(bramEN), .wen(bramWEN), .addr(bramAddr),
    .wrData(bramDout), .rdData(bramDin)
  );

  // untouched memory holds a pattern of its own byte address
  function automatic logic [63:0] fillPattern(input logic [31:0] byteAddr);
    return {byteAddr ^ 32'h3c5a_0000, ~byteAddr};
  endfunction

  task automatic checkValue(input string name, input logic [63:0] actual,
                            input logic [63:0] expected);
    if (actual !== expected) begin
      errorCount = errorCount + 1;
      $display("error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      $display("=== FAIL ===");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic reportTimeout(input string what);
    $display("timeout: no %s within %0d clock cycles", what, doneTimeout);
    $display("=== FAIL ===");
    $fatal(1, "wait timed out");
  endtask

  task automatic runCase(input int idx);
    caseRow row;
    int cycles;
    int reqBefore;
    int i;
    logic [8:0] srcAt;
    logic [8:0] dstAt;
    logic [63:0] want;
    row = cases[3'(idx)];
    // slave setup and start on a falling edge
    ackDelay = 8'(row.ackDelay);
    errEnable = (row.errIdx >= 0);
    errRead = 16'(row.errIdx);
    srcBase = row.srcBase;
    dstBase = row.dstBase;
    wordCount = row.wordCount;
    reqBefore = reqCycles;
    start = 1'b1;
    @(negedge CLK);
    start = 1'b0;
    cycles = 1;
    while (done !== 1'b1) begin
      if (cycles >= doneTimeout) begin
        reportTimeout($sformatf("done in case %0d", idx));
      end
      @(negedge CLK);
      cycles = cycles + 1;
    end
    checkValue("error", 64'(error), 64'(row.expError));
    if (row.wordCount == 16'd0) begin
      checkValue("done latency", 64'(cycles), 64'd1);
    end
    @(negedge CLK);
    // single-cycle pulse
    checkValue("done", 64'(done), 64'd0);
    // zero count never reaches the bus
    if (row.wordCount == 16'd0) begin
      checkValue("mRequest cycles", 64'(reqCycles - reqBefore), 64'd0);
    end
    // one word past the region must be untouched too
    for (i = 0; i <= int'(row.wordCount); i++) begin
      srcAt = 9'(int'(row.srcBase >> 3) + i);
      dstAt = 9'(int'(row.dstBase >> 3) + i);
      want = (i < row.expWritten) ? image[srcAt] : image[dstAt];
      checkValue($sformatf("case %0d dst word %0d", idx, i), i_plbSlaveMem.mem[dstAt], want);
    end
  endtask

  // request phase checks away from the rising edge
  always @(negedge CLK) begin
    if (!reset && mRequest) begin
      checkValue("mBE", 64'(mBE), 64'hff);
      checkValue("mABus[2:0]", 64'(mABus[2:0]), 64'd0);
    end
  end

  // request cycles as the slave samples them
  always @(posedge CLK) begin
    if (!reset && mRequest) begin
      reqCycles = reqCycles + 1;
    end
  end

  initial begin
    int r;
    int i;
    reset = 1'b1;
    start = 1'b0;
    srcBase = '0;
    dstBase = '0;
    wordCount = '0;
    ackDelay = '0;
    errEnable = 1'b0;
    errRead = '0;
    loadEn = 1'b0;
    loadIdx = '0;
    loadData = '0;
    seed = 32'h14;

    // sources in the lower half and destinations in the upper half
    cases[0] = '{32'h000, 32'h800, 16'd5, 0, -1, 1'b0, 5};
    // more doublewords than the FIFO holds with slow acks
    cases[1] = '{32'h100, 32'h900, 16'd20, 3, -1, 1'b0, 20};
    cases[2] = '{32'h300, 32'ha00, 16'd10, 1, 4, 1'b1, 4};
    cases[3] = '{32'h400, 32'hb00, 16'd0, 0, -1, 1'b0, 0};
    cases[4] = '{32'h500, 32'hc00, 16'd6, 2, 0, 1'b1, 0};
    // err together with the address ack
    cases[5] = '{32'h600, 32'hd00, 16'd3, 0, 2, 1'b1, 2};
    // clean copy after the failures
    cases[6] = '{32'h700, 32'he00, 16'd8, 1, -1, 1'b0, 8};

    for (i = 0; i < memWords; i++) begin
      if (i < memWords / 2) begin
        image[9'(i)] = {$random(seed), $random(seed)};
      end else begin
        image[9'(i)] = fillPattern(32'(i * 8));
      end
    end

    repeat (4) @(negedge CLK);
    checkValue("mRequest", 64'(mRequest), 64'd0);
    checkValue("bramEN", 64'(bramEN), 64'd0);
    checkValue("bramWEN", 64'(bramWEN), 64'd0);
    checkValue("done", 64'(done), 64'd0);
    checkValue("error", 64'(error), 64'd0);
    checkValue("bramRST", 64'(bramRST), 64'd1);
    reset = 1'b0;

    // backdoor load of one doubleword per cycle
    for (i = 0; i < memWords; i++) begin
      loadEn = 1'b1;
      loadIdx = 9'(i);
      loadData = image[9'(i)];
      @(negedge CLK);
    end
    loadEn = 1'b0;
    @(negedge CLK);

    for (r = 0; r < numCases; r++) begin
      runCase(r);
    end

    if (errorCount == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* common/fifoPortIf.sv */
`timescale 1ns/1ps
// push and pop port of the BRAM FIFO
interface fifoPortIf;

  // push side, ignored while full
  logic push;
  logic [testerPkg::bramDataWidth-1:0] pushData;
  logic full;

  // pop side, ignored while empty
  logic pop;
  logic empty;
  // data lands one cycle after the pop
  logic [testerPkg::bramDataWidth-1:0] popData;
  logic popValid;

  modport pusher (output push, pushData, input full);

  modport popper (output pop, input empty, popData, popValid);

  modport fifo (
    input  push, pushData, pop,
    output full, empty, popData, popValid
  );

endinterface

/* common/plbReqIf.sv */
`timescale 1ns/1ps
// PLB request channel between one copy engine and the arbiter
// single-beat subset, one transfer in flight
interface plbReqIf;

  // request side, held stable until addrAck
  logic request;
  logic rnw;
  logic [testerPkg::plbAddrWidth-1:0] addr;
  logic [testerPkg::plbDataWidth-1:0] wrData;

  // response side, only the granted engine sees these
  logic addrAck;
  logic wrDAck;
  logic rdDAck;
  logic [testerPkg::plbDataWidth-1:0] rdData;
  // ends either kind of transfer as failed
  logic err;

  modport engine (
    output request, rnw, addr, wrData,
    input  addrAck, wrDAck, rdDAck, rdData, err
  );

  modport arbiter (
    input  request, rnw, addr, wrData,
    output addrAck, wrDAck, rdDAck, rdData, err
  );

endinterface

/* common/testerPkg.sv */
// BRAM FIFO tester shared definitions
// bus widths, FIFO geometry and engine state encodings
package testerPkg;

  // PLB master port
  localparam int plbAddrWidth = 32;
  localparam int plbDataWidth = 64;
  localparam int plbBeWidth = plbDataWidth / 8;

  // address stride from one doubleword to the next
  localparam logic [plbAddrWidth-1:0] dwordBytes = 8;

  // BRAM initiator port, one 32-bit entry per address
  localparam int bramAddrWidth = 32;
  localparam int bramDataWidth = 32;
  localparam int bramWenWidth = bramDataWidth / 8;

  // FIFO geometry, a doubleword takes two entries
  localparam int fifoAddrBits = 4;
  localparam int fifoDepth = 1 << fifoAddrBits;

  // doublewords per copy
  localparam int countWidth = 16;

  typedef enum logic [2:0] {
    fillIdle,
    fillRequest,
    fillWaitData,
    fillPushLow,
    fillPushHigh
  } fillState;

  typedef enum logic [2:0] {
    drainIdle,
    drainPopLow,
    drainPopHigh,
    drainRequest,
    drainWaitAck
  } drainState;

endpackage

/* fifoTester/bramFifoCtrl.sv */
`timescale 1ns/1ps
// BRAM FIFO controller
// head and tail pointers over an external block RAM, one port
// shared by push and pop with pop first on a collision
module bramFifoCtrl (
  input  logic CLK,
  input  logic reset,
  fifoPortIf.fifo fifo,
  output logic [testerPkg::bramAddrWidth-1:0] bramAddr,
  output logic [testerPkg::bramDataWidth-1:0] bramDout,
  output logic [testerPkg::bramWenWidth-1:0] bramWEN,
  output logic bramEN,
  input  logic [testerPkg::bramDataWidth-1:0] bramDin
);

  // extra top bit tells a full ring from an empty one
  logic [testerPkg::fifoAddrBits:0] head;
  logic [testerPkg::fifoAddrBits:0] tail;
  logic [testerPkg::fifoAddrBits:0] occupancy;
  logic [testerPkg::fifoAddrBits-1:0] slot;
  logic ptrFull;
  logic popOk;
  logic pushOk;
  logic popValidQ;

  assign occupancy = tail - head;
  assign ptrFull = (occupancy == testerPkg::fifoDepth);
  assign fifo.empty = (occupancy == '0);

  assign popOk = fifo.pop && !fifo.empty;
  // a pop owns the port this cycle, so the pusher sees full
  assign fifo.full = ptrFull || popOk;
  assign pushOk = fifo.push && !fifo.full;

  // read at head, write at tail
  assign slot = popOk ? head[testerPkg::fifoAddrBits-1:0] : tail[testerPkg::fifoAddrBits-1:0];

  // byte address of a 32-bit entry
  assign bramAddr = {{(testerPkg::bramAddrWidth - testerPkg::fifoAddrBits - 2){1'b0}},
                     slot, 2'b00};
  assign bramEN = popOk || pushOk;
  assign bramWEN = pushOk ? '1 : '0;
  assign bramDout = fifo.pushData;

  // read data is registered inside the BRAM
  assign fifo.popData = bramDin;
  assign fifo.popValid = popValidQ;

  always_ff @(posedge CLK) begin
    if (reset) begin
      head <= '0;
      tail <= '0;
      popValidQ <= 1'b0;
    end else begin
      popValidQ <= popOk;
      if (popOk) begin
        head <= head + 1'b1;
      end
      if (pushOk) begin
        tail <= tail + 1'b1;
      end
    end
  end

  // head stays behind tail by at most one ring
  assert property (@(posedge CLK) disable iff (reset)
    occupancy <= testerPkg::fifoDepth)
    else $error("FIFO head passed tail");

endmodule

/* fifoTester/drainEngine.sv */
`timescale 1ns/1ps
// drain engine
// pops entry pairs from the FIFO and writes each pair as one
// doubleword to the destination, then reports done and error
module drainEngine (
  input  logic CLK,
  input  logic reset,
  input  logic start,
  input  logic [testerPkg::plbAddrWidth-1:0] dstBase,
  input  logic [testerPkg::countWidth-1:0] wordCount,
  input  logic fillErr,
  plbReqIf.engine plb,
  fifoPortIf.popper fifo,
  output logic done,
  output logic error
);

  testerPkg::drainState state;
  logic [testerPkg::plbAddrWidth-1:0] addrQ;
  logic [testerPkg::countWidth-1:0] countQ;
  logic [testerPkg::countWidth-1:0] idxQ;
  logic [testerPkg::plbDataWidth-1:0] dataQ;
  logic inWrite;
  logic wordDone;
  logic lastWord;

  // pop only when there is something to pop
  assign fifo.pop = ((state == testerPkg::drainPopLow) || (state == testerPkg::drainPopHigh))
      && !fifo.empty;

  // first request cycle still has the high entry landing
  assign plb.request = (state == testerPkg::drainRequest) && !fifo.popValid;
  assign plb.rnw = 1'b0;
  assign plb.addr = addrQ;
  assign plb.wrData = dataQ;

  assign inWrite = (state == testerPkg::drainRequest) || (state == testerPkg::drainWaitAck);
  // write ack can arrive together with the address ack
  assign wordDone = inWrite && plb.wrDAck && !plb.err
      && (plb.addrAck || (state == testerPkg::drainWaitAck));
  assign lastWord = (idxQ + 1'b1) == countQ;

  always_ff @(posedge CLK) begin
    if (reset) begin
      state <= testerPkg::drainIdle;
      idxQ <= '0;
      done <= 1'b0;
      error <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        testerPkg::drainIdle: begin
          if (start) begin
            error <= 1'b0;
            idxQ <= '0;
            if (wordCount == '0) begin
              done <= 1'b1;
            end else begin
              state <= testerPkg::drainPopLow;
            end
          end
        end
        testerPkg::drainPopLow: begin
          if (fifo.pop) begin
            state <= testerPkg::drainPopHigh;
          end else if (fillErr) begin
            // everything read before the failure is already written
            done <= 1'b1;
            error <= 1'b1;
            state <= testerPkg::drainIdle;
          end
        end
        testerPkg::drainPopHigh: begin
          if (fifo.pop) begin
            state <= testerPkg::drainRequest;
          end
        end
        testerPkg::drainRequest,
        testerPkg::drainWaitAck: begin
          if (plb.err) begin
            done <= 1'b1;
            error <= 1'b1;
            state <= testerPkg::drainIdle;
          end else if (wordDone) begin
            idxQ <= idxQ + 1'b1;
            if (lastWord) begin
              done <= 1'b1;
              state <= testerPkg::drainIdle;
            end else begin
              state <= testerPkg::drainPopLow;
            end
          end else if (plb.addrAck) begin
            state <= testerPkg::drainWaitAck;
          end
        end
        default: state <= testerPkg::drainIdle;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if ((state == testerPkg::drainIdle) && start) begin
      addrQ <= dstBase;
      countQ <= wordCount;
    end else if (wordDone) begin
      addrQ <= addrQ + testerPkg::dwordBytes;
    end
    // low entry shifts down when the high one arrives
    if (fifo.popValid) begin
      dataQ <= {fifo.popData, dataQ[testerPkg::plbDataWidth-1:testerPkg::bramDataWidth]};
    end
  end

  // pops only while data waits, and every pop returns data next cycle
  assert property (@(posedge CLK) disable iff (reset)
    fifo.pop |-> !fifo.empty ##1 fifo.popValid)
    else $error("drain pop while empty or without data");

endmodule

/* fifoTester/fillEngine.sv */
`timescale 1ns/1ps
// fill engine
// reads source doublewords over PLB and pushes each into the FIFO
// as a low entry followed by a high entry
module fillEngine (
  input  logic CLK,
  input  logic reset,
  input  logic start,
  input  logic [testerPkg::plbAddrWidth-1:0] srcBase,
  input  logic [testerPkg::countWidth-1:0] wordCount,
  plbReqIf.engine plb,
  fifoPortIf.pusher fifo,
  output logic fillErr
);

  testerPkg::fillState state;
  logic [testerPkg::plbAddrWidth-1:0] addrQ;
  logic [testerPkg::countWidth-1:0] countQ;
  logic [testerPkg::countWidth-1:0] idxQ;
  logic [testerPkg::plbDataWidth-1:0] dataQ;
  logic reqHeld;
  logic lastWord;
  logic highPushed;

  // reads only, write data unused
  assign plb.rnw = 1'b1;
  assign plb.addr = addrQ;
  assign plb.wrData = '0;

  // hold off a new read while the FIFO is full
  // once raised the request stays up until addrAck
  assign plb.request = (state == testerPkg::fillRequest) && (reqHeld || !fifo.full);

  assign fifo.push = (state == testerPkg::fillPushLow) || (state == testerPkg::fillPushHigh);
  assign fifo.pushData = (state == testerPkg::fillPushHigh) ?
      dataQ[testerPkg::plbDataWidth-1:testerPkg::bramDataWidth] :
      dataQ[testerPkg::bramDataWidth-1:0];

  assign highPushed = (state == testerPkg::fillPushHigh) && !fifo.full;
  assign lastWord = (idxQ + 1'b1) == countQ;

  always_ff @(posedge CLK) begin
    if (reset) begin
      state <= testerPkg::fillIdle;
      reqHeld <= 1'b0;
      fillErr <= 1'b0;
      idxQ <= '0;
    end else begin
      reqHeld <= plb.request && !plb.addrAck && !plb.err;
      case (state)
        testerPkg::fillIdle: begin
          if (start) begin
            fillErr <= 1'b0;
            idxQ <= '0;
            // zero count never leaves idle
            if (wordCount != '0) begin
              state <= testerPkg::fillRequest;
            end
          end
        end
        testerPkg::fillRequest: begin
          if (plb.err) begin
            fillErr <= 1'b1;
            state <= testerPkg::fillIdle;
          end else if (plb.addrAck) begin
            // data may come back with the address ack
            state <= plb.rdDAck ? testerPkg::fillPushLow : testerPkg::fillWaitData;
          end
        end
        testerPkg::fillWaitData: begin
          if (plb.err) begin
            fillErr <= 1'b1;
            state <= testerPkg::fillIdle;
          end else if (plb.rdDAck) begin
            state <= testerPkg::fillPushLow;
          end
        end
        testerPkg::fillPushLow: begin
          if (!fifo.full) begin
            state <= testerPkg::fillPushHigh;
          end
        end
        testerPkg::fillPushHigh: begin
          if (highPushed) begin
            idxQ <= idxQ + 1'b1;
            state <= lastWord ? testerPkg::fillIdle : testerPkg::fillRequest;
          end
        end
        default: state <= testerPkg::fillIdle;
      endcase
    end
  end

  // source address and the doubleword being moved
  always_ff @(posedge CLK) begin
    if ((state == testerPkg::fillIdle) && start) begin
      addrQ <= srcBase;
      countQ <= wordCount;
    end else if (highPushed) begin
      addrQ <= addrQ + testerPkg::dwordBytes;
    end
    if (plb.rdDAck) begin
      dataQ <= plb.rdData;
    end
  end

  // request must survive arbitration and slave delay
  assert property (@(posedge CLK) disable iff (reset)
    plb.request && !plb.addrAck && !plb.err |=> plb.request)
    else $error("fill request dropped before addrAck");

endmodule

/* fifoTester/plbArbiter.sv */
`timescale 1ns/1ps
// PLB arbiter
// shares the single master port between the fill and drain engines
// round robin between grants and each grant held until its data phase ends
module plbArbiter (
  input  logic CLK,
  input  logic reset,
  plbReqIf.arbiter fill,
  plbReqIf.arbiter drain,
  output logic mRequest,
  output logic mRNW,
  output logic [testerPkg::plbAddrWidth-1:0] mABus,
  output logic [testerPkg::plbBeWidth-1:0] mBE,
  output logic [testerPkg::plbDataWidth-1:0] mWrDBus,
  input  logic mAddrAck,
  input  logic mWrDAck,
  input  logic mRdDAck,
  input  logic [testerPkg::plbDataWidth-1:0] mRdDBus,
  input  logic mErr
);

  // engine select is 0 for fill and 1 for drain
  logic granted;
  logic grantSel;
  logic lastWinner;
  logic pick;
  logic sel;
  logic active;
  logic xferDone;

  // both asking goes to the one that lost last time
  assign pick = (fill.request && drain.request) ? ~lastWinner : drain.request;
  assign sel = granted ? grantSel : pick;
  assign mRequest = sel ? drain.request : fill.request;
  assign active = granted || mRequest;
  assign xferDone = mRdDAck || mWrDAck || mErr;

  // forward the selected engine
  assign mRNW = sel ? drain.rnw : fill.rnw;
  assign mABus = sel ? drain.addr : fill.addr;
  assign mWrDBus = sel ? drain.wrData : fill.wrData;
  // full doubleword on every beat
  assign mBE = mRequest ? '1 : '0;

  // responses to the owner only
  assign fill.addrAck = active && !sel && mAddrAck;
  assign fill.wrDAck = active && !sel && mWrDAck;
  assign fill.rdDAck = active && !sel && mRdDAck;
  assign fill.err = active && !sel && mErr;
  assign fill.rdData = (active && !sel) ? mRdDBus : '0;
  assign drain.addrAck = active && sel && mAddrAck;
  assign drain.wrDAck = active && sel && mWrDAck;
  assign drain.rdDAck = active && sel && mRdDAck;
  assign drain.err = active && sel && mErr;
  assign drain.rdData = (active && sel) ? mRdDBus : '0;

  always_ff @(posedge CLK) begin
    if (reset) begin
      granted <= 1'b0;
      grantSel <= 1'b0;
      // fill wins the first tie
      lastWinner <= 1'b1;
    end else if (granted) begin
      if (xferDone) begin
        granted <= 1'b0;
      end
    end else if (mRequest) begin
      // single-cycle transfers never hold the grant
      granted <= !xferDone;
      grantSel <= sel;
      lastWinner <= sel;
    end
  end

  // an ack or error only comes back while an engine owns the port
  assert property (@(posedge CLK) disable iff (reset)
    (mAddrAck || xferDone) |-> active)
    else $error("PLB response with no engine granted");

  // owner does not change while a transfer is open
  assert property (@(posedge CLK) disable iff (reset)
    granted && !xferDone |=> granted && $stable(grantSel))
    else $error("PLB grant moved mid transfer");

endmodule

/* filelist.f */
common/testerPkg.sv
common/plbReqIf.sv
common/fifoPortIf.sv
fifoTester/fillEngine.sv
fifoTester/drainEngine.sv
fifoTester/bramFifoCtrl.sv
fifoTester/plbArbiter.sv
src/bramFifoTester.sv
bench/busModels.sv
bench/tbBramFifoTester.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert -j 0 --top-module tbBramFifoTester -f filelist.f -o simv \
  && ./obj_dir/simv | tee sim.log
grep -qx "=== PASS ===" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* src/bramFifoTester.sv */
`timescale 1ns/1ps
// BRAM FIFO tester top level
// copies doublewords from source to destination over PLB, staging
// every word in a FIFO held in external block RAM
module bramFifoTester (
  input  logic CLK,
  input  logic reset,
  // control
  input  logic start,
  input  logic [testerPkg::plbAddrWidth-1:0] srcBase,
  input  logic [testerPkg::plbAddrWidth-1:0] dstBase,
  input  logic [testerPkg::countWidth-1:0] wordCount,
  output logic done,
  output logic error,
  // PLB master
  output logic mRequest,
  output logic mRNW,
  output logic [testerPkg::plbAddrWidth-1:0] mABus,
  output logic [testerPkg::plbBeWidth-1:0] mBE,
  output logic [testerPkg::plbDataWidth-1:0] mWrDBus,
  input  logic mAddrAck,
  input  logic mWrDAck,
  input  logic mRdDAck,
  input  logic [testerPkg::plbDataWidth-1:0] mRdDBus,
  input  logic mErr,
  // BRAM initiator
  output logic [testerPkg::bramAddrWidth-1:0] bramAddr,
  output logic [testerPkg::bramDataWidth-1:0] bramDout,
  output logic [testerPkg::bramWenWidth-1:0] bramWEN,
  output logic bramEN,
  output logic bramCLK,
  output logic bramRST,
  input  logic [testerPkg::bramDataWidth-1:0] bramDin
);

  plbReqIf fillPlb ();
  plbReqIf drainPlb ();
  fifoPortIf fifoPort ();

  // fill failure ends the drain side
  logic fillErr;

  // BRAM runs off the tester clock and reset
  assign bramCLK = CLK;
  assign bramRST = reset;

  fillEngine i_fillEngine (
    .CLK       (CLK),
    .reset     (reset),
    .start     (start),
    .srcBase   (srcBase),
    .wordCount (wordCount),
    .plb       (fillPlb.engine),
    .fifo      (fifoPort.pusher),
    .fillErr   (fillErr)
  );

  drainEngine i_drainEngine (
    .CLK       (CLK),
    .reset     (reset),
    .start     (start),
    .dstBase   (dstBase),
    .wordCount (wordCount),
    .fillErr   (fillErr),
    .plb       (drainPlb.engine),
    .fifo      (fifoPort.popper),
    .done      (done),
    .error     (error)
  );

  bramFifoCtrl i_bramFifoCtrl (
    .CLK      (CLK),
    .reset    (reset),
    .fifo     (fifoPort.fifo),
    .bramAddr (bramAddr),
    .bramDout (bramDout),
    .bramWEN  (bramWEN),
    .bramEN   (bramEN),
    .bramDin  (bramDin)
  );

  plbArbiter i_plbArbiter (
    .CLK      (CLK),
    .reset    (reset),
    .fill     (fillPlb.arbiter),
    .drain    (drainPlb.arbiter),
    .mRequest (mRequest),
    .mRNW     (mRNW),
    .mABus    (mABus),
    .mBE      (mBE),
    .mWrDBus  (mWrDBus),
    .mAddrAck (mAddrAck),
    .mWrDAck  (mWrDAck),
    .mRdDAck  (mRdDAck),
    .mRdDBus  (mRdDBus),
    .mErr     (mErr)
  );

endmodule
